//--- include/doodle_consts.svh
`ifndef DOODLE_CONSTS_SVH
`define DOODLE_CONSTS_SVH

// visible screen area
`define SCREEN_X_MAX 10'd639
`define SCREEN_Y_MAX 10'd479

// sprite sizes, all half extents
`define DOODLE_SIZE 10'd6
`define PLAT_HALF_X 10'd20
`define PLAT_HALF_Y 10'd3

// vertical motion, speeds in pixels per frame
`define GRAVITY_DIV 4           // frames per gravity step
`define JUMP_SPEED  10'sd10
`define MAX_FALL    10'sd8
`define STEP_X      10'd3

// horizontal wrap
`define WRAP_MARGIN 10'd25
`define WRAP_LEFT   10'd96
`define WRAP_RIGHT  10'd543

`define SCROLL_LINE 10'd240

`define START_X 10'd330
`define START_Y 10'd300

// keyboard usage codes, each direction has two keys
`define KEY_LEFT      8'd4
`define KEY_LEFT_ALT  8'd80
`define KEY_RIGHT     8'd7
`define KEY_RIGHT_ALT 8'd79
`define KEY_START     8'd40
`define KEY_PAUSE     8'd19

`endif

//--- design/doodle_pkg.sv
package doodle_pkg;

	// screen position in pixels
	typedef logic [9:0] coord_t;

	// per-frame displacement, positive is down or right
	typedef logic signed [9:0] speed_t;

	typedef enum logic [1:0]
	{
		Menu,
		Play,
		Pause,
		Scroll   // waiting for the platform generator
	} gameMode_t;

	typedef struct packed
	{
		coord_t x;   // centre
		coord_t y;
	} platform_t;

	typedef logic [11:0] score_t;

endpackage

//--- design/modeControl.sv
`timescale 1ns/1ps
`include "doodle_consts.svh"

module modeControl
(
	input logic Reset,                       // frame clock
	input logic frame_clk,                   // async reset, active high
	input logic [7:0] keycode,
	input logic scrollReq,
	input logic trigger,
	output doodle_pkg::gameMode_t mode,
	output logic scrollEn
);

	logic [7:0] prevKey;
	logic pausePress;

	// the pause key is a level, only its first frame counts
	assign pausePress = (keycode == `KEY_PAUSE) && (prevKey != `KEY_PAUSE);

	// the generator sees the request for the whole scroll wait
	assign scrollEn = (mode == doodle_pkg::Scroll);

	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
		begin
			mode <= doodle_pkg::Menu;
			prevKey <= 8'd0;
		end
		else
		begin
			prevKey <= keycode;
			case (mode)
				doodle_pkg::Menu:
				begin
					if (keycode == `KEY_START)
						mode <= doodle_pkg::Play;
				end
				doodle_pkg::Play:
				begin
					// physics clamps the doodle on this same edge, so scroll wins over pause
					if (scrollReq)
						mode <= doodle_pkg::Scroll;
					else if (pausePress)
						mode <= doodle_pkg::Pause;
				end
				doodle_pkg::Pause:
				begin
					if (pausePress)
						mode <= doodle_pkg::Play;
				end
				doodle_pkg::Scroll:
				begin
					if (trigger)              // generator finished shifting
						mode <= doodle_pkg::Play;
				end
				default:
					mode <= doodle_pkg::Menu;
			endcase
		end
	end

endmodule

//--- design/platformHit.sv
`timescale 1ns/1ps
`include "doodle_consts.svh"

module platformHit
#(
	parameter int numPlat = 16
)
(
	input doodle_pkg::coord_t doodleX,
	input doodle_pkg::coord_t doodleY,
	input doodle_pkg::platform_t plats [numPlat],
	output logic onPlatform
);

	// horizontal reach from platform centre to doodle centre
	localparam logic [10:0] ReachX = 11'(`PLAT_HALF_X + `DOODLE_SIZE);
	localparam logic [10:0] HalfY = 11'(`PLAT_HALF_Y);

	logic [10:0] feet;
	logic [10:0] centreX;
	logic [10:0] platX;
	logic [10:0] platY;

	// one extra bit so no sum wraps
	assign feet = 11'(doodleY) + 11'(`DOODLE_SIZE);
	assign centreX = 11'(doodleX);

	always_comb
	begin
		onPlatform = 1'b0;
		platX = 11'd0;
		platY = 11'd0;
		for (int i = 0; i < numPlat; i++)
		begin
			platX = 11'(plats[i].x);
			platY = 11'(plats[i].y);
			// differences are written as sums to stay unsigned
			if ((feet <= platY + HalfY) && (feet + HalfY >= platY)
				&& (platX + ReachX >= centreX) && (platX <= centreX + ReachX))
				onPlatform = 1'b1;
		end
	end

endmodule

//--- design/doodlePhysics.sv
`timescale 1ns/1ps
`include "doodle_consts.svh"

module doodlePhysics
(
	input logic Reset,                       // frame clock
	input logic frame_clk,                   // async reset
	input doodle_pkg::gameMode_t mode,
	input logic [7:0] keycode,
	input logic onPlatform,
	output doodle_pkg::coord_t doodleX,
	output doodle_pkg::coord_t doodleY,
	output doodle_pkg::speed_t speedY,
	output logic scrollReq
);

	localparam int GravW = $clog2(`GRAVITY_DIV);

	logic [GravW-1:0] gravCnt;
	doodle_pkg::coord_t feetY;
	logic falling;
	logic keyLeft;
	logic keyRight;
	logic landed;

	assign feetY = doodleY + `DOODLE_SIZE;
	assign falling = (speedY > 10'sd0);
	assign landed = falling && ((feetY >= `SCREEN_Y_MAX) || onPlatform);

	assign keyLeft = (keycode == `KEY_LEFT) || (keycode == `KEY_LEFT_ALT);
	assign keyRight = (keycode == `KEY_RIGHT) || (keycode == `KEY_RIGHT_ALT);

	// rising through the scroll line with nothing to stand on
	assign scrollReq = (speedY < 10'sd0) && (doodleY <= `SCROLL_LINE) && !onPlatform;

	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
		begin
			doodleX <= `START_X;
			doodleY <= `START_Y;
			speedY <= 10'sd0;
			gravCnt <= '0;
		end
		else
		begin
			case (mode)
				doodle_pkg::Menu:
				begin
					// parked at the start point until play begins
					doodleX <= `START_X;
					doodleY <= `START_Y;
					speedY <= 10'sd0;
					gravCnt <= '0;
				end
				doodle_pkg::Play:
				begin
					// horizontal, wrap has priority over steering
					if (doodleX >= `SCREEN_X_MAX - `WRAP_MARGIN)
						doodleX <= `WRAP_LEFT;
					else if (doodleX <= `WRAP_MARGIN + `DOODLE_SIZE)
						doodleX <= `WRAP_RIGHT;
					else if (keyRight)
						doodleX <= doodleX + `STEP_X;
					else if (keyLeft)
						doodleX <= doodleX - `STEP_X;

					if (scrollReq)
					begin
						// hold at the line while the platforms move down
						doodleY <= `SCROLL_LINE;
						speedY <= 10'sd0;
						gravCnt <= '0;
					end
					else
					begin
						doodleY <= doodleY + doodle_pkg::coord_t'(speedY);   // old speed
						if (landed)
						begin
							speedY <= -`JUMP_SPEED;
							gravCnt <= '0;
						end
						else if (gravCnt == GravW'(`GRAVITY_DIV - 1))
						begin
							gravCnt <= '0;
							if (speedY < `MAX_FALL)
								speedY <= speedY + 10'sd1;
						end
						else
							gravCnt <= gravCnt + 1'b1;
					end
				end
				default:
				begin
					// pause and scroll freeze everything
				end
			endcase
		end
	end

endmodule

//--- design/scoreTracker.sv
`timescale 1ns/1ps
`include "doodle_consts.svh"

module scoreTracker
(
	input logic Reset,                       // frame clock
	input logic frame_clk,                   // async reset
	input doodle_pkg::gameMode_t mode,
	input doodle_pkg::coord_t doodleY,
	output doodle_pkg::score_t score
);

	doodle_pkg::coord_t bestY;   // highest point reached, smallest Y

	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
		begin
			bestY <= `START_Y;
			score <= '0;
		end
		else if (mode == doodle_pkg::Menu)
		begin
			bestY <= `START_Y;
			score <= '0;
		end
		else if ((mode == doodle_pkg::Play) && (doodleY < bestY))
		begin
			score <= score + doodle_pkg::score_t'(bestY - doodleY);   // new height only
			bestY <= doodleY;
		end
	end

endmodule

//--- design/doodleGame.sv
`timescale 1ns/1ps

module doodleGame
#(
	parameter int numPlat = 16
)
(
	input logic Reset,                       // frame clock
	input logic frame_clk,                   // async reset
	input logic [7:0] keycode,
	input logic trigger,                     // platform generator done
	input doodle_pkg::platform_t plats [numPlat],
	output logic scrollEn,
	output doodle_pkg::gameMode_t mode,
	output doodle_pkg::coord_t doodleX,
	output doodle_pkg::coord_t doodleY,
	output doodle_pkg::speed_t speedY,
	output doodle_pkg::score_t score
);

	logic scrollReq;
	logic onPlatform;

	modeControl modeCtl
	(
		.Reset(Reset),
		.frame_clk(frame_clk),
		.keycode(keycode),
		.scrollReq(scrollReq),
		.trigger(trigger),
		.mode(mode),
		.scrollEn(scrollEn)
	);

	platformHit #(.numPlat(numPlat)) hitTest
	(
		.doodleX(doodleX),
		.doodleY(doodleY),
		.plats(plats),
		.onPlatform(onPlatform)
	);

	doodlePhysics physics
	(
		.Reset(Reset),
		.frame_clk(frame_clk),
		.mode(mode),
		.keycode(keycode),
		.onPlatform(onPlatform),
		.doodleX(doodleX),
		.doodleY(doodleY),
		.speedY(speedY),
		.scrollReq(scrollReq)
	);

	scoreTracker scoring
	(
		.Reset(Reset),
		.frame_clk(frame_clk),
		.mode(mode),
		.doodleY(doodleY),
		.score(score)
	);

endmodule

//--- tb/tb_doodleGame.sv
`timescale 1ns/1ps
`include "doodle_consts.svh"

module tb_doodleGame;

	localparam int NumPlat = 16;

	logic Reset;                             // frame clock
	logic frame_clk;                         // async reset
	logic [7:0] keycode;
	logic trigger;
	doodle_pkg::platform_t plats [NumPlat];
	logic scrollEn;
	doodle_pkg::gameMode_t mode;
	doodle_pkg::coord_t doodleX;
	doodle_pkg::coord_t doodleY;
	doodle_pkg::speed_t speedY;
	doodle_pkg::score_t score;

	int errors = 0;
	bit timedOut = 1'b0;

	// values one frame back, taken on the rising edge
	doodle_pkg::gameMode_t prevMode = doodle_pkg::Menu;
	doodle_pkg::coord_t prevX = `START_X;
	doodle_pkg::coord_t prevY = `START_Y;
	doodle_pkg::speed_t prevSpeed = '0;
	doodle_pkg::score_t prevScore = '0;
	logic [7:0] prevKey = '0;
	logic [7:0] olderKey = '0;
	logic prevTrig = 1'b0;
	logic prevHit = 1'b0;
	logic prevScroll = 1'b0;
	doodle_pkg::coord_t minY = `START_Y;   // highest point since the menu

	logic refHit;
	logic refScroll;
	logic wasPlay;
	logic wasFrozen;
	logic pauseEdge;
	logic midX;

	doodleGame #(.numPlat(NumPlat)) dut
	(
		.Reset(Reset), .frame_clk(frame_clk), .keycode(keycode), .trigger(trigger),
		.plats(plats), .scrollEn(scrollEn), .mode(mode), .doodleX(doodleX),
		.doodleY(doodleY), .speedY(speedY), .score(score)
	);

	// feet inside the platform thickness and the two spans overlapping
	function automatic logic overlaps(doodle_pkg::platform_t p, int x, int y);
		int dy;
		int dx;
		dy = y + int'(`DOODLE_SIZE) - int'(p.y);
		dx = x - int'(p.x);
		return (dy >= -int'(`PLAT_HALF_Y)) && (dy <= int'(`PLAT_HALF_Y))
			&& (dx >= -int'(`PLAT_HALF_X + `DOODLE_SIZE)) && (dx <= int'(`PLAT_HALF_X + `DOODLE_SIZE));
	endfunction

	function automatic logic isRightKey(logic [7:0] k);
		return (k == `KEY_RIGHT) || (k == `KEY_RIGHT_ALT);
	endfunction

	function automatic logic isLeftKey(logic [7:0] k);
		return (k == `KEY_LEFT) || (k == `KEY_LEFT_ALT);
	endfunction

	always_comb
	begin
		refHit = 1'b0;
		for (int i = 0; i < NumPlat; i++)
			if (overlaps(plats[i], int'(doodleX), int'(doodleY)))
				refHit = 1'b1;
	end

	assign refScroll = (speedY < 0) && (doodleY <= `SCROLL_LINE) && !refHit;
	assign wasPlay = (prevMode == doodle_pkg::Play);
	assign wasFrozen = (prevMode == doodle_pkg::Pause) || (prevMode == doodle_pkg::Scroll);
	assign pauseEdge = (prevKey == `KEY_PAUSE) && (olderKey != `KEY_PAUSE);   // first frame only
	assign midX = (prevX > `WRAP_MARGIN + `DOODLE_SIZE) && (prevX < `SCREEN_X_MAX - `WRAP_MARGIN);

	always @(posedge Reset)
	begin
		prevMode <= mode;
		prevX <= doodleX;
		prevY <= doodleY;
		prevSpeed <= speedY;
		prevScore <= score;
		prevKey <= keycode;
		olderKey <= prevKey;
		prevTrig <= trigger;
		prevHit <= refHit;
		prevScroll <= refScroll;
		if (mode == doodle_pkg::Menu)
			minY <= `START_Y;
		else if (doodleY < minY)
			minY <= doodleY;
	end

	task automatic reportValue(string name, int expected, int actual);
		errors++;
		$display("Fail at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
	endtask

	// checked mid-frame, where nothing moves
	assert property (@(negedge Reset) (mode == doodle_pkg::Menu) |-> (doodleX == `START_X))
		else reportValue("doodleX", `START_X, doodleX);
	assert property (@(negedge Reset) (mode == doodle_pkg::Menu) |-> (doodleY == `START_Y))
		else reportValue("doodleY", `START_Y, doodleY);
	assert property (@(negedge Reset) (mode == doodle_pkg::Menu) |-> (speedY == 0))
		else reportValue("speedY", 0, speedY);
	assert property (@(negedge Reset) (mode == doodle_pkg::Menu) |-> (score == 0))
		else reportValue("score", 0, score);
	assert property (@(negedge Reset) (mode == doodle_pkg::Menu) |-> !scrollEn)
		else reportValue("scrollEn", 0, scrollEn);
	assert property (@(negedge Reset) speedY <= `MAX_FALL)
		else reportValue("speedY", `MAX_FALL, speedY);
	assert property (@(negedge Reset) (wasPlay && !prevScroll) |-> (speedY <= prevSpeed + 1))
		else reportValue("speedY", prevSpeed + 1, speedY);
	assert property (@(negedge Reset) (wasPlay && !prevScroll)
		|-> (doodleY == doodle_pkg::coord_t'(prevY + prevSpeed)))
		else reportValue("doodleY", doodle_pkg::coord_t'(prevY + prevSpeed), doodleY);
	// floor, then platform landing
	assert property (@(negedge Reset) (wasPlay && (prevSpeed > 0)
		&& (prevY + `DOODLE_SIZE >= `SCREEN_Y_MAX)) |-> (speedY == -`JUMP_SPEED))
		else reportValue("speedY", -`JUMP_SPEED, speedY);
	assert property (@(negedge Reset) (wasPlay && (prevSpeed > 0) && prevHit)
		|-> (speedY == -`JUMP_SPEED))
		else reportValue("speedY", -`JUMP_SPEED, speedY);
	assert property (@(negedge Reset) (wasPlay && (prevSpeed > 0) && !prevHit
		&& (prevY + `DOODLE_SIZE < `SCREEN_Y_MAX)) |-> (speedY >= prevSpeed))
		else reportValue("speedY", prevSpeed, speedY);
	assert property (@(negedge Reset) (wasPlay && midX && isRightKey(prevKey))
		|-> (doodleX == prevX + `STEP_X))
		else reportValue("doodleX", prevX + `STEP_X, doodleX);
	assert property (@(negedge Reset) (wasPlay && midX && isLeftKey(prevKey))
		|-> (doodleX == prevX - `STEP_X))
		else reportValue("doodleX", prevX - `STEP_X, doodleX);
	assert property (@(negedge Reset) (wasPlay && (prevX >= `SCREEN_X_MAX - `WRAP_MARGIN))
		|-> (doodleX == `WRAP_LEFT))
		else reportValue("doodleX", `WRAP_LEFT, doodleX);
	assert property (@(negedge Reset) (wasPlay && (prevX <= `WRAP_MARGIN + `DOODLE_SIZE))
		|-> (doodleX == `WRAP_RIGHT))
		else reportValue("doodleX", `WRAP_RIGHT, doodleX);
	assert property (@(negedge Reset) (wasPlay && pauseEdge && !prevScroll)
		|-> (mode == doodle_pkg::Pause))
		else reportValue("mode", doodle_pkg::Pause, mode);
	assert property (@(negedge Reset) ((prevMode == doodle_pkg::Pause) && pauseEdge)
		|-> (mode == doodle_pkg::Play))
		else reportValue("mode", doodle_pkg::Play, mode);
	assert property (@(negedge Reset) wasFrozen |-> (doodleX == prevX))
		else reportValue("doodleX", prevX, doodleX);
	assert property (@(negedge Reset) wasFrozen |-> (doodleY == prevY))
		else reportValue("doodleY", prevY, doodleY);
	assert property (@(negedge Reset) wasFrozen |-> (speedY == prevSpeed))
		else reportValue("speedY", prevSpeed, speedY);
	assert property (@(negedge Reset) wasFrozen |-> (score == prevScore))
		else reportValue("score", prevScore, score);
	assert property (@(negedge Reset) (wasPlay && prevScroll) |-> (doodleY == `SCROLL_LINE))
		else reportValue("doodleY", `SCROLL_LINE, doodleY);
	assert property (@(negedge Reset) (wasPlay && prevScroll) |-> (mode == doodle_pkg::Scroll))
		else reportValue("mode", doodle_pkg::Scroll, mode);
	assert property (@(negedge Reset) (wasPlay && prevScroll) |-> scrollEn)
		else reportValue("scrollEn", 1, scrollEn);
	assert property (@(negedge Reset) ((prevMode == doodle_pkg::Scroll) && !prevTrig)
		|-> (mode == doodle_pkg::Scroll))
		else reportValue("mode", doodle_pkg::Scroll, mode);
	assert property (@(negedge Reset) ((prevMode == doodle_pkg::Scroll) && prevTrig) |-> !scrollEn)
		else reportValue("scrollEn", 0, scrollEn);
	assert property (@(negedge Reset) wasPlay |-> (score >= prevScore))
		else reportValue("score", prevScore, score);
	assert property (@(negedge Reset) score == `START_Y - minY)
		else reportValue("score", `START_Y - minY, score);

	initial
	begin
		Reset = 1'b0;
		forever
			#10 Reset = ~Reset;
	end

	task automatic nextCycle();
		@(posedge Reset);
		#2;
	endtask

	task automatic holdKey(logic [7:0] k, int frames);
		keycode = k;
		repeat (frames) nextCycle();
	endtask

	// steps frames until mode, or doodleX when onX is set, takes the value
	task automatic waitUntil(bit onX, int value, int limit, string what);
		int n;
		n = 0;
		while (!timedOut && !(onX ? (int'(doodleX) == value) : (int'(mode) == value)))
		begin
			if (n == limit)
			begin
				timedOut = 1'b1;
				errors++;
				$display("Timeout: %s not seen within %0d frames", what, limit);
			end
			else
			begin
				nextCycle();
				n++;
			end
		end
	endtask

	// a column of four platforms, under the doodle or far to the side
	task automatic placePlatforms(bit near);
		int offset;
		for (int i = 0; i < 4; i++)
		begin
			offset = int'($urandom_range(30)) - 15;
			plats[i].x = near ? doodle_pkg::coord_t'(int'(doodleX) + offset)
				: ((doodleX < 10'd320) ? 10'd600 : 10'd40);
			plats[i].y = doodle_pkg::coord_t'(350 + 6 * i);
		end
	endtask

	initial
	begin
		frame_clk = 1'b1;
		keycode = 8'd0;
		trigger = 1'b0;
		for (int i = 0; i < NumPlat; i++)
			plats[i] = '{x: 10'd0, y: 10'd1000};   // off screen
		void'($urandom(72));
		repeat (2) @(posedge Reset);
		#2;
		frame_clk = 1'b0;
		holdKey(`KEY_PAUSE, 1 + $urandom_range(3));
		holdKey(`KEY_LEFT_ALT, 1 + $urandom_range(3));
		holdKey(`KEY_RIGHT, 1 + $urandom_range(3));
		holdKey(`KEY_START, 1);
		keycode = 8'd0;
		waitUntil(1'b0, doodle_pkg::Play, 4, "Play after start key");
		holdKey(8'd0, 120);   // fall and floor bounces
		keycode = $urandom_range(1) ? `KEY_RIGHT : `KEY_RIGHT_ALT;
		waitUntil(1'b1, `WRAP_LEFT, 200, "wrap to the left side");
		holdKey(keycode, 5 + $urandom_range(15));
		keycode = $urandom_range(1) ? `KEY_LEFT : `KEY_LEFT_ALT;
		waitUntil(1'b1, `WRAP_RIGHT, 200, "wrap to the right side");
		holdKey(keycode, 5 + $urandom_range(15));
		holdKey(`KEY_PAUSE, 2 + $urandom_range(5));
		waitUntil(1'b0, doodle_pkg::Pause, 2, "Pause after pause key");
		holdKey(8'd0, 5 + $urandom_range(10));
		holdKey(`KEY_PAUSE, 2 + $urandom_range(4));
		waitUntil(1'b0, doodle_pkg::Play, 2, "Play after second pause key");
		keycode = 8'd0;
		for (int round = 0; round < 2; round++)
		begin
			placePlatforms(1'b1);
			waitUntil(1'b0, doodle_pkg::Scroll, 400, "scroll request");
			holdKey(8'd0, 3 + $urandom_range(12));
			placePlatforms(1'b0);   // shifted out of the doodle's span
			trigger = 1'b1;
			nextCycle();
			trigger = 1'b0;
			waitUntil(1'b0, doodle_pkg::Play, 2, "Play after trigger");
			holdKey(8'd0, 150);
		end
		$display("Run finished with %0d errors", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- sources.f
+incdir+include
design/doodle_pkg.sv
design/modeControl.sv
design/platformHit.sv
design/doodlePhysics.sv
design/scoreTracker.sv
design/doodleGame.sv
tb/tb_doodleGame.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_doodleGame -f sources.f \
	&& ./obj_dir/Vtb_doodleGame | tee /dev/stderr | grep -x "No errors" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
